/* vlog.f */
+incdir+.
bru_pkg.sv
bru_issue_queue.sv
bru_resolve.sv
bru_bim_table.sv
bru_top.sv
tb_bru.sv

/* Makefile */
SRCS := bru_macros.svh bru_pkg.sv bru_issue_queue.sv bru_resolve.sv \
        bru_bim_table.sv bru_top.sv tb_bru.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_bru: $(SRCS) vlog.f
	verilator --binary --timing -Wno-fatal --top-module tb_bru -f vlog.f -o Vtb_bru

run: obj_dir/Vtb_bru
	./obj_dir/Vtb_bru | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_bru.sv */
// Branch execution unit testbench
// Directed tests push micro-ops through dispatch and compare branch updates,
// link writebacks and predictor counters with a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_bru;

  localparam int TIMEOUT = 50;  // Cycles per wait

  logic                 clk;
  logic                 rst;
  bru_pkg::disp_t       disp;
  logic                 disp_ready;
  bru_pkg::br_upd_t     br_upd;
  bru_pkg::wb_t         wb;
  bru_pkg::gshare_idx_t lookup_index;
  logic [1:0]           lookup_counter;

  int          errors;
  int          checks;
  int          seq;        // Next cmt_id and brtag
  logic [31:0] rng_state;

  bru_pkg::br_upd_t exp_upd[$];
  bru_pkg::br_upd_t got_upd[$];
  bru_pkg::wb_t     exp_wb[$];
  bru_pkg::wb_t     got_wb[$];

  bru_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .disp           (disp),
    .disp_ready     (disp_ready),
    .br_upd         (br_upd),
    .wb             (wb),
    .lookup_index   (lookup_index),
    .lookup_counter (lookup_counter)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Registered outputs settle by mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (br_upd.update) got_upd.push_back(br_upd);
      if (wb.valid) got_wb.push_back(wb);
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus and reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic bru_pkg::xlen_t rand_offset();
    logic [31:0] r;
    r = xorshift32();
    return {{19{r[12]}}, r[12:1], 1'b0};  // Even and sign extended
  endfunction

  function automatic logic is_jump(bru_pkg::br_op_t op);
    return (op == bru_pkg::BR_JAL) || (op == bru_pkg::BR_JALR);
  endfunction

  function automatic logic model_taken(bru_pkg::disp_t d);
    logic t;
    case (d.op)
      bru_pkg::BR_EQ:  t = (d.rs1_data == d.rs2_data);
      bru_pkg::BR_NE:  t = (d.rs1_data != d.rs2_data);
      bru_pkg::BR_LT:  t = ($signed(d.rs1_data) < $signed(d.rs2_data));
      bru_pkg::BR_GE:  t = ($signed(d.rs1_data) >= $signed(d.rs2_data));
      bru_pkg::BR_LTU: t = (d.rs1_data < d.rs2_data);
      bru_pkg::BR_GEU: t = (d.rs1_data >= d.rs2_data);
      default:         t = 1'b1;
    endcase
    return t;
  endfunction

  function automatic bru_pkg::vaddr_t model_target(bru_pkg::disp_t d);
    bru_pkg::vaddr_t t;
    if (d.op == bru_pkg::BR_JALR) begin
      t = d.rs1_data + d.imm;
      t[0] = 1'b0;
    end else begin
      t = d.pc_vaddr + d.imm;
    end
    return t;
  endfunction

  function automatic bru_pkg::br_upd_t model_upd(bru_pkg::disp_t d);
    bru_pkg::br_upd_t u;
    logic             t;
    bru_pkg::vaddr_t  tgt;
    t = model_taken(d);
    tgt = model_target(d);
    u.update       = 1'b1;
    u.taken        = t;
    u.mispredict   = (t != d.pred_taken) || (t && (tgt != d.pred_target_vaddr));
    u.is_cond      = !is_jump(d.op);
    u.pc_vaddr     = d.pc_vaddr;
    u.target_vaddr = tgt;
    u.cmt_id       = d.cmt_id;
    u.brtag        = d.brtag;
    u.gshare_index = d.gshare_index;
    return u;
  endfunction

  function automatic bru_pkg::wb_t model_wb(bru_pkg::disp_t d);
    bru_pkg::wb_t w;
    w.valid = is_jump(d.op) && d.wr_valid;
    w.rnid  = d.wr_rnid;
    w.data  = d.pc_vaddr + (d.is_rvc ? 32'd2 : 32'd4);
    return w;
  endfunction

  // Correctly predicted micro-op
  function automatic bru_pkg::disp_t make_op(bru_pkg::br_op_t op, bru_pkg::vaddr_t pc,
      bru_pkg::xlen_t rs1, bru_pkg::xlen_t rs2, bru_pkg::xlen_t imm, logic is_rvc);
    bru_pkg::disp_t d;
    d = '0;
    d.valid        = 1'b1;
    d.pc_vaddr     = pc;
    d.op           = op;
    d.is_rvc       = is_rvc;
    d.rs1_data     = rs1;
    d.rs2_data     = rs2;
    d.imm          = imm;
    d.gshare_index = bru_pkg::gshare_idx_t'(pc >> 2);
    d.wr_valid     = 1'b1;
    d.wr_rnid      = bru_pkg::rnid_t'(pc >> 1);
    d.pred_taken   = model_taken(d);
    d.pred_target_vaddr = model_target(d);
    return d;
  endfunction

  // ----------------------------------------------------------------------
  // Driving and collecting
  // ----------------------------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  task automatic send(input bru_pkg::disp_t d);
    int waited;
    waited = 0;
    disp = d;
    disp.valid = 1'b1;
    while (!disp_ready && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    if (!disp_ready) begin
      $display("ERROR: dispatch of cmt_id %0d was never accepted", d.cmt_id);
      errors++;
    end
    tick();  // Accepting edge
    disp.valid = 1'b0;
  endtask

  task automatic expect_send(input bru_pkg::disp_t d);
    bru_pkg::wb_t w;
    d.cmt_id = bru_pkg::cmt_id_t'(seq);
    d.brtag  = bru_pkg::brtag_t'(seq);
    seq++;
    w = model_wb(d);
    exp_upd.push_back(model_upd(d));
    if (w.valid) exp_wb.push_back(w);
    send(d);
  endtask

  task automatic wait_updates(input int n);
    int waited;
    waited = 0;
    while (got_upd.size() < n && waited < TIMEOUT) begin
      tick();
      waited++;
    end
    if (got_upd.size() < n) begin
      $display("ERROR: only %0d of %0d branch updates arrived", got_upd.size(), n);
      errors++;
    end
  endtask

  task automatic check_upd(input string name, input bru_pkg::br_upd_t exp,
                           input bru_pkg::br_upd_t act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_wb(input string name, input bru_pkg::wb_t exp, input bru_pkg::wb_t act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_counter(input string name, input logic [1:0] exp,
                               input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic collect(input string name);
    wait_updates(exp_upd.size());
    if (got_upd.size() > exp_upd.size()) begin
      $display("ERROR: %s saw %0d branch updates, expected %0d", name, got_upd.size(),
               exp_upd.size());
      errors++;
    end
    for (int i = 0; i < exp_upd.size() && i < got_upd.size(); i++) begin
      check_upd(name, exp_upd[i], got_upd[i]);
    end
    if (got_wb.size() != exp_wb.size()) begin
      $display("ERROR: %s saw %0d link writebacks, expected %0d", name, got_wb.size(),
               exp_wb.size());
      errors++;
    end
    for (int i = 0; i < exp_wb.size() && i < got_wb.size(); i++) begin
      check_wb(name, exp_wb[i], got_wb[i]);
    end
    exp_upd.delete();
    got_upd.delete();
    exp_wb.delete();
    got_wb.delete();
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_cond();
    bru_pkg::xlen_t rs1;
    bru_pkg::xlen_t rs2;
    for (int k = 0; k < 6; k++) begin
      for (int i = 0; i < 4; i++) begin
        rs1 = xorshift32();
        rs2 = xorshift32();
        if (i == 0) rs2 = rs1;
        if (i == 1) begin
          rs1[31] = 1'b1;  // Negative against positive
          rs2[31] = 1'b0;
        end
        if (i == 2) begin
          rs1[31] = 1'b0;
          rs2[31] = 1'b1;
        end
        expect_send(make_op(bru_pkg::br_op_t'(k), xorshift32() & 32'hffff_fffc, rs1, rs2,
                            rand_offset(), (xorshift32() & 32'd1) != 32'd0));
      end
    end
    collect("cond");
  endtask

  task automatic test_jump();
    bru_pkg::disp_t d;
    expect_send(make_op(bru_pkg::BR_JAL, 32'h0000_1000, 32'd0, 32'd0, 32'h0000_0100, 1'b0));
    expect_send(make_op(bru_pkg::BR_JAL, 32'h0000_2002, 32'd0, 32'd0, 32'hffff_ff00, 1'b1));
    expect_send(make_op(bru_pkg::BR_JALR, 32'h0000_3000, 32'h0000_8001, 32'd0, 32'd6, 1'b0));
    expect_send(make_op(bru_pkg::BR_JALR, 32'h0000_4006, 32'h0000_9000, 32'd0, 32'd3, 1'b1));
    d = make_op(bru_pkg::BR_JAL, 32'h0000_5000, 32'd0, 32'd0, 32'h0000_0040, 1'b0);
    d.wr_valid = 1'b0;  // No link register
    expect_send(d);
    d = make_op(bru_pkg::BR_JALR, 32'h0000_6000, 32'h0000_a005, 32'd0, 32'd0, 1'b1);
    d.wr_valid = 1'b0;
    expect_send(d);
    collect("jump");
  endtask

  task automatic test_mispredict();
    bru_pkg::disp_t d;
    d = make_op(bru_pkg::BR_EQ, 32'h0000_7000, 32'd9, 32'd9, 32'h0000_0020, 1'b0);
    d.pred_taken = 1'b0;  // Wrong direction
    expect_send(d);
    collect("mispredict_dir");
    d = make_op(bru_pkg::BR_NE, 32'h0000_7100, 32'd1, 32'd1, 32'h0000_0020, 1'b0);
    d.pred_taken = 1'b1;
    expect_send(d);
    collect("mispredict_not_taken");
    d = make_op(bru_pkg::BR_JAL, 32'h0000_7200, 32'd0, 32'd0, 32'h0000_0080, 1'b0);
    d.pred_target_vaddr = d.pred_target_vaddr + 32'd8;  // Right direction but wrong target
    expect_send(d);
    collect("mispredict_target");
  endtask

  task automatic test_flush();
    bru_pkg::disp_t d;
    logic [2:0]     ready_seen;
    d = make_op(bru_pkg::BR_LT, 32'h0000_8000, 32'd1, 32'd2, 32'h0000_0040, 1'b0);
    d.pred_taken = 1'b0;
    expect_send(d);
    // Three younger ops back to back with the third in the flush cycle
    for (int k = 0; k < 3; k++) begin
      disp = make_op(bru_pkg::BR_GEU, 32'h0000_8004 + 4 * k, 32'd7, 32'd3, 32'd16, 1'b0);
      disp.cmt_id = bru_pkg::cmt_id_t'(seq);
      disp.brtag  = bru_pkg::brtag_t'(seq);
      seq++;
      ready_seen[k] = disp_ready;
      tick();
    end
    disp.valid = 1'b0;
    checks++;
    if (ready_seen !== 3'b011) begin
      $display("MISMATCH flush_ready: expected %b, actual %b", 3'b011, ready_seen);
      errors++;
    end
    wait_updates(1);
    repeat (6) tick();  // Room for any younger update to leak out
    collect("flush");
    expect_send(make_op(bru_pkg::BR_NE, 32'h0000_9000, 32'd4, 32'd5, 32'h0000_0010, 1'b0));
    collect("flush_after");
  endtask

  // Resolve drains one entry per cycle, so back-to-back dispatch never fills the queue
  task automatic test_back_to_back();
    for (int k = 0; k < 5; k++) begin
      if (!disp_ready) begin
        $display("ERROR: back-to-back dispatch %0d found disp_ready low", k);
        errors++;
      end
      expect_send(make_op(bru_pkg::br_op_t'(k), 32'h0000_a000 + 8 * k, xorshift32(),
                          xorshift32(), rand_offset(), 1'b0));
    end
    collect("back_to_back");
  endtask

  task automatic test_counter();
    bru_pkg::disp_t       d;
    bru_pkg::gshare_idx_t idx;
    logic [1:0]           exp_cnt;
    logic                 taken;
    idx = 6'd21;
    exp_cnt = 2'd1;
    lookup_index = idx;
    tick();
    check_counter("counter_reset", exp_cnt, lookup_counter);
    for (int k = 0; k < 7; k++) begin
      taken = (k < 3);
      d = make_op(taken ? bru_pkg::BR_EQ : bru_pkg::BR_NE, 32'h0000_b000 + 4 * k, 32'd5,
                  32'd5, 32'h0000_0010, 1'b0);
      d.gshare_index = idx;
      expect_send(d);
      collect("counter_update");
      if (taken && exp_cnt != 2'd3) exp_cnt = exp_cnt + 2'd1;
      if (!taken && exp_cnt != 2'd0) exp_cnt = exp_cnt - 2'd1;
      lookup_index = idx;
      tick();
      check_counter("counter_train", exp_cnt, lookup_counter);
    end
    d = make_op(bru_pkg::BR_JAL, 32'h0000_c000, 32'd0, 32'd0, 32'h0000_0010, 1'b0);
    d.gshare_index = idx;
    expect_send(d);
    collect("counter_jump");
    tick();
    check_counter("counter_jump", exp_cnt, lookup_counter);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    seq = 0;
    rng_state = 32'd52;
    rst = 1'b1;
    disp = '0;
    lookup_index = '0;
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;
    tick();
    test_counter();  // Counters still hold their reset value here
    test_cond();
    test_jump();
    test_mispredict();
    test_flush();
    test_back_to_back();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bru_top.sv */
// Branch execution unit top level
// Dispatch feeds the issue queue, the queue feeds the resolve pipeline,
// and the resulting branch update trains the bimodal counter table.
// The resolve pipeline's flush empties the queue on a mispredict.
`timescale 1ns/1ps
`default_nettype none

module bru_top (
  input  logic                  clk,
  input  logic                  rst,
  input  bru_pkg::disp_t        disp,
  output logic                  disp_ready,
  output bru_pkg::br_upd_t      br_upd,
  output bru_pkg::wb_t          wb,
  input  bru_pkg::gshare_idx_t  lookup_index,
  output logic [1:0]            lookup_counter
);

  bru_pkg::issue_entry_t issue;
  logic                  flush;

  bru_issue_queue u_queue (
    .clk        (clk),
    .rst        (rst),
    .disp       (disp),
    .disp_ready (disp_ready),
    .flush      (flush),
    .issue      (issue)
  );

  bru_resolve u_resolve (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .br_upd (br_upd),
    .wb     (wb),
    .flush  (flush)
  );

  bru_bim_table u_bim (
    .clk            (clk),
    .rst            (rst),
    .br_upd         (br_upd),
    .lookup_index   (lookup_index),
    .lookup_counter (lookup_counter)
  );

endmodule

`default_nettype wire

/* bru_bim_table.sv */
// Bimodal counter table
// Gshare-indexed 2-bit saturating counters trained by conditional branch
// updates, with a one-cycle registered lookup port for the front end
`timescale 1ns/1ps
`default_nettype none

`include "bru_macros.svh"

module bru_bim_table (
  input  logic                  clk,
  input  logic                  rst,
  input  bru_pkg::br_upd_t      br_upd,
  input  bru_pkg::gshare_idx_t  lookup_index,
  output logic [1:0]            lookup_counter
);

  localparam int NUM_CNT = 1 << `BRU_GSHARE_W;

  logic [1:0] cnt [NUM_CNT];

  logic       train;
  logic [1:0] cur_cnt;
  logic [1:0] next_cnt;

  assign train   = br_upd.update && br_upd.is_cond;  // Jumps never train
  assign cur_cnt = cnt[br_upd.gshare_index];

  // ----------------------------------------------------------------------
  // Saturating step
  // ----------------------------------------------------------------------
  always_comb begin
    next_cnt = cur_cnt;
    if (br_upd.taken) begin
      if (cur_cnt != 2'd3) begin
        next_cnt = cur_cnt + 2'd1;
      end
    end else begin
      if (cur_cnt != 2'd0) begin
        next_cnt = cur_cnt - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt[i] <= `BRU_BIM_INIT;
      end
    end else if (train) begin
      cnt[br_upd.gshare_index] <= next_cnt;
    end
  end

  // ----------------------------------------------------------------------
  // Lookup port
  // ----------------------------------------------------------------------
  // Same-cycle update to the looked-up index returns the old value
  always_ff @(posedge clk) begin
    lookup_counter <= cnt[lookup_index];
  end

endmodule

`default_nettype wire

/* bru_resolve.sv */
// Branch resolve pipeline
// Stage 1 latches the issued micro-op and evaluates its condition.
// Stage 2 forms the target and link value, detects a mispredict and
// drives the branch update, the link writeback and the unit flush.
`timescale 1ns/1ps
`default_nettype none

module bru_resolve (
  input  logic                   clk,
  input  logic                   rst,
  input  bru_pkg::issue_entry_t  issue,
  output bru_pkg::br_upd_t       br_upd,
  output bru_pkg::wb_t           wb,
  output logic                   flush
);

  logic                  issue_taken;
  logic                  s1_valid;
  bru_pkg::issue_entry_t s1_entry;
  logic                  s1_taken;

  logic                  s1_is_jalr;
  logic                  s1_is_cond;
  bru_pkg::vaddr_t       s1_target;
  bru_pkg::xlen_t        s1_link;
  logic                  s1_mispred;
  logic                  s1_fire;

  // ----------------------------------------------------------------------
  // Stage 1: condition
  // ----------------------------------------------------------------------
  always_comb begin
    case (issue.op)
      bru_pkg::BR_EQ:   issue_taken = (issue.rs1_data == issue.rs2_data);
      bru_pkg::BR_NE:   issue_taken = (issue.rs1_data != issue.rs2_data);
      bru_pkg::BR_LT:   issue_taken = ($signed(issue.rs1_data) < $signed(issue.rs2_data));
      bru_pkg::BR_GE:   issue_taken = ($signed(issue.rs1_data) >= $signed(issue.rs2_data));
      bru_pkg::BR_LTU:  issue_taken = (issue.rs1_data < issue.rs2_data);
      bru_pkg::BR_GEU:  issue_taken = (issue.rs1_data >= issue.rs2_data);
      default:          issue_taken = 1'b1;  // JAL, JALR
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue.valid && !flush;  // Head is younger than the flusher
    end
  end

  always_ff @(posedge clk) begin
    s1_entry <= issue;
    s1_taken <= issue_taken;
  end

  // ----------------------------------------------------------------------
  // Stage 2: target, link and mispredict
  // ----------------------------------------------------------------------
  assign s1_is_jalr = (s1_entry.op == bru_pkg::BR_JALR);
  assign s1_is_cond = !(s1_is_jalr || (s1_entry.op == bru_pkg::BR_JAL));

  always_comb begin
    if (s1_is_jalr) begin
      s1_target = bru_pkg::vaddr_t'(s1_entry.rs1_data + s1_entry.imm);
      s1_target[0] = 1'b0;
    end else begin
      s1_target = s1_entry.pc_vaddr + bru_pkg::vaddr_t'(s1_entry.imm);
    end
  end

  assign s1_link = bru_pkg::xlen_t'(s1_entry.pc_vaddr) +
                   (s1_entry.is_rvc ? bru_pkg::xlen_t'(2) : bru_pkg::xlen_t'(4));

  assign s1_mispred = (s1_taken != s1_entry.pred_taken) ||
                      (s1_taken && (s1_target != s1_entry.pred_target_vaddr));

  assign s1_fire = s1_valid && !flush;  // Stage 1 dropped on flush

  always_ff @(posedge clk) begin
    if (rst) begin
      br_upd <= '0;
      wb     <= '0;
      flush  <= 1'b0;
    end else begin
      br_upd.update       <= s1_fire;
      br_upd.taken        <= s1_taken;
      br_upd.mispredict   <= s1_mispred;
      br_upd.is_cond      <= s1_is_cond;
      br_upd.pc_vaddr     <= s1_entry.pc_vaddr;
      br_upd.target_vaddr <= s1_target;
      br_upd.cmt_id       <= s1_entry.cmt_id;
      br_upd.brtag        <= s1_entry.brtag;
      br_upd.gshare_index <= s1_entry.gshare_index;
      wb.valid            <= s1_fire && !s1_is_cond && s1_entry.wr_valid;
      wb.rnid             <= s1_entry.wr_rnid;
      wb.data             <= s1_link;
      flush               <= s1_fire && s1_mispred;
    end
  end

endmodule

`default_nettype wire

/* bru_issue_queue.sv */
// Branch issue queue
// In-order circular buffer between dispatch and the resolve pipeline.
// Every held entry is ready, so the head issues each cycle it exists.
// A mispredict flush empties the queue and refuses dispatch that cycle.
`timescale 1ns/1ps
`default_nettype none

`include "bru_macros.svh"

module bru_issue_queue (
  input  logic                   clk,
  input  logic                   rst,
  input  bru_pkg::disp_t         disp,
  output logic                   disp_ready,
  input  logic                   flush,
  output bru_pkg::issue_entry_t  issue
);

  localparam int DEPTH = `BRU_ENTRY_SIZE;
  localparam int PTR_W = $clog2(DEPTH);

  bru_pkg::issue_entry_t mem [DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;

  logic push;
  logic pop;
  logic full;

  assign full       = (count == (PTR_W+1)'(DEPTH));
  assign disp_ready = !full && !flush;
  assign push       = disp.valid && disp_ready;
  assign pop        = (count != '0);  // Resolve never stalls

  // ----------------------------------------------------------------------
  // Head presented straight to resolve
  // ----------------------------------------------------------------------
  always_comb begin
    issue       = mem[head];
    issue.valid = pop;
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      head  <= tail;                   // All held entries are younger
      count <= '0;
    end else begin
      if (push) begin
        tail <= (tail == PTR_W'(DEPTH-1)) ? '0 : tail + 1'b1;
      end
      if (pop) begin
        head <= (head == PTR_W'(DEPTH-1)) ? '0 : head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[tail].valid             <= 1'b1;
      mem[tail].pc_vaddr          <= disp.pc_vaddr;
      mem[tail].op                <= disp.op;
      mem[tail].is_rvc            <= disp.is_rvc;
      mem[tail].rs1_data          <= disp.rs1_data;
      mem[tail].rs2_data          <= disp.rs2_data;
      mem[tail].imm               <= disp.imm;
      mem[tail].brtag             <= disp.brtag;
      mem[tail].cmt_id            <= disp.cmt_id;
      mem[tail].pred_taken        <= disp.pred_taken;
      mem[tail].pred_target_vaddr <= disp.pred_target_vaddr;
      mem[tail].gshare_index      <= disp.gshare_index;
      mem[tail].wr_valid          <= disp.wr_valid;
      mem[tail].wr_rnid           <= disp.wr_rnid;
    end
  end

endmodule

`default_nettype wire

/* bru_pkg.sv */
// Branch execution unit package
// Scalar types, the branch op encoding and the structs carried between
// dispatch, the issue queue, the resolve pipeline and the predictor
`default_nettype none

`include "bru_macros.svh"

package bru_pkg;

  typedef logic [`BRU_VADDR_W-1:0]  vaddr_t;
  typedef logic [`BRU_XLEN-1:0]     xlen_t;
  typedef logic [`BRU_BRTAG_W-1:0]  brtag_t;
  typedef logic [`BRU_CMT_ID_W-1:0] cmt_id_t;
  typedef logic [`BRU_RNID_W-1:0]   rnid_t;
  typedef logic [`BRU_GSHARE_W-1:0] gshare_idx_t;

  // Conditional ops first, jumps last
  typedef enum logic [2:0] {
    BR_EQ   = 3'd0,
    BR_NE   = 3'd1,
    BR_LT   = 3'd2,
    BR_GE   = 3'd3,
    BR_LTU  = 3'd4,
    BR_GEU  = 3'd5,
    BR_JAL  = 3'd6,
    BR_JALR = 3'd7
  } br_op_t;

  // ----------------------------------------------------------------------
  // Dispatch and issue
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic        valid;
    vaddr_t      pc_vaddr;
    br_op_t      op;
    logic        is_rvc;             // 16-bit encoding
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    xlen_t       imm;
    brtag_t      brtag;
    cmt_id_t     cmt_id;
    logic        pred_taken;
    vaddr_t      pred_target_vaddr;
    gshare_idx_t gshare_index;
    logic        wr_valid;           // Link register written
    rnid_t       wr_rnid;
  } disp_t;

  typedef struct packed {
    logic        valid;
    vaddr_t      pc_vaddr;
    br_op_t      op;
    logic        is_rvc;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    xlen_t       imm;
    brtag_t      brtag;
    cmt_id_t     cmt_id;
    logic        pred_taken;
    vaddr_t      pred_target_vaddr;
    gshare_idx_t gshare_index;
    logic        wr_valid;
    rnid_t       wr_rnid;
  } issue_entry_t;

  // ----------------------------------------------------------------------
  // Resolve results
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic        update;
    logic        taken;
    logic        mispredict;
    logic        is_cond;
    vaddr_t      pc_vaddr;
    vaddr_t      target_vaddr;
    cmt_id_t     cmt_id;
    brtag_t      brtag;
    gshare_idx_t gshare_index;
  } br_upd_t;

  typedef struct packed {
    logic  valid;
    rnid_t rnid;
    xlen_t data;
  } wb_t;

endpackage

`default_nettype wire

/* bru_macros.svh */
// Branch execution unit sizes
// Widths of addresses, operands, tags and IDs, plus the issue queue depth
// and the counter table geometry shared by the package and the RTL
`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
`define BRU_VADDR_W     32   // Virtual address
`define BRU_XLEN        32   // Operand width

// ----------------------------------------------------------------------
// Tags and IDs
// ----------------------------------------------------------------------
`define BRU_BRTAG_W     3
`define BRU_CMT_ID_W    5
`define BRU_RNID_W      6    // Physical register ID

// ----------------------------------------------------------------------
// Structure sizes
// ----------------------------------------------------------------------
`define BRU_ENTRY_SIZE  4    // Issue queue depth
`define BRU_GSHARE_W    6    // 64 counters
`define BRU_BIM_INIT    2'd1 // Weakly not taken

`endif
